// ==== filelist.f ====
+incdir+include
verilog/uart_pkg.sv
verilog/uart_rx.sv
verilog/cmd_decode.sv
verilog/reg_execute.sv
verilog/resp_result.sv
verilog/uart_tx.sv
verilog/uart_cmd_top.sv
verification/uart_cmd_properties.sv
verification/uart_cmd_tb.sv

// ==== include/uart_params.svh ====
/*
	Fixed widths shared by the UART command responder.
	cycles per bit must be at least 2 at run time.
*/
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// payload bits per frame
`define UART_DATA_BITS 8

// width of the run-time cycles per bit input, up to 1023 cycles
`define UART_CPB_W 10

// registers reachable by the command set
`define UART_NUM_REGS 4

// start + data + stop
`define UART_FRAME_BITS 10

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator from the project root
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f filelist.f --top-module uart_cmd_tb \
		-o uart_cmd_sim \
	&& ./obj_dir/uart_cmd_sim | tee /dev/stderr | grep -q "Simulation passed" \
	&& echo "run_sim: PASS" \
	|| { echo "run_sim: FAIL"; exit 1; }

// ==== verification/uart_cmd_properties.sv ====
/*
	Control checks on the responder top level, bound into every uart_cmd_top.
*/
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_properties
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic rx_valid_i,
	input wire logic tx_start_i,
	input wire logic tx_busy_i,
	input wire logic tx_line_i
);

	// busy rises on the edge after a launch
	start_then_busy: assert property (@(posedge clk) disable iff (!resetn)
		tx_start_i |=> tx_busy_i)
		else $error("tx_busy did not follow tx_start");

	valid_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		rx_valid_i |=> !rx_valid_i)
		else $error("rx_valid longer than one cycle");

	// last bit before the transmitter goes idle is the stop bit
	stop_bit_high: assert property (@(posedge clk) disable iff (!resetn)
		$fell(tx_busy_i) |-> $past(tx_line_i))
		else $error("frame ended without a high stop bit");

endmodule

bind uart_cmd_top uart_cmd_properties i_props
(
	.clk(clk),
	.resetn(resetn),
	.rx_valid_i(rx_valid),
	.tx_start_i(tx_start),
	.tx_busy_i(tx_busy),
	.tx_line_i(tx_o)
);

`default_nettype wire

// ==== verification/uart_cmd_tb.sv ====
/*
	Testbench for the UART register command responder, cycles per bit fixed at 16.
	Host frames are driven 1 ns after the rising edge; tx_o is sampled on falling edges.
	The first error stops the run.
*/
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_cmd_tb;

	localparam int CPB = 16;
	localparam int START_TIMEOUT = 40 * CPB; // cycles allowed before a response starts
	localparam int NV = 17;

	// {command, expected response}, op[7:6] addr[5:4] nib[3:0]
	localparam logic [0:NV-1][15:0] VECS =
	{
		16'h80_00, 16'h90_00, 16'hA0_00, 16'hB0_00, // all registers clear after reset
		16'h15_05, 16'h5A_A5, 16'h90_A5, // lo then hi nibble of reg 1
		16'h23_03, 16'h7C_C0, 16'h0F_0F, 16'h6E_E3, 16'h31_C1,
		16'h80_0F, 16'h90_A5, 16'hA0_E3, 16'hB0_C1, // read back all four
		16'hC1_10 // addi 1 to reg 0
	};

	logic clk;
	logic resetn;
	logic rx_i;
	logic [`UART_CPB_W-1:0] cycles_per_bit;
	logic tx_o;

	logic [`UART_DATA_BITS-1:0] got_a;
	logic [`UART_DATA_BITS-1:0] got_b;
	logic [`UART_DATA_BITS-1:0] reg0_model;
	logic [`UART_DATA_BITS-1:0] cmd;
	logic [31:0] rnd_state;

	uart_cmd_top i_dut
	(
		.clk(clk),
		.resetn(resetn),
		.rx_i(rx_i),
		.cycles_per_bit_i(cycles_per_bit),
		.tx_o(tx_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic compare_byte(input string name, input logic [`UART_DATA_BITS-1:0] got,
		input logic [`UART_DATA_BITS-1:0] exp);
		if (got !== exp)
		begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic compare_line(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// one 8N1 frame at line rate, lsb first
	task automatic send_byte(input logic [`UART_DATA_BITS-1:0] b);
		logic [`UART_FRAME_BITS-1:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < `UART_FRAME_BITS; i++)
		begin
			@(posedge clk);
			#1 rx_i = frame[i];
			repeat (CPB - 1) @(posedge clk);
		end
	endtask

	task automatic receive_byte(output logic [`UART_DATA_BITS-1:0] b);
		int waited;
		waited = 0;
		while (tx_o !== 1'b0)
		begin
			@(negedge clk);
			waited++;
			if (waited > START_TIMEOUT)
				stop_with_failure("no response start bit seen on tx_o within the timeout");
		end
		repeat (CPB / 2) @(negedge clk); // middle of the start bit
		compare_line("tx_o start bit", tx_o, 1'b0);
		for (int i = 0; i < `UART_DATA_BITS; i++)
		begin
			repeat (CPB) @(negedge clk);
			b[i] = tx_o;
		end
		repeat (CPB) @(negedge clk);
		compare_line("tx_o stop bit", tx_o, 1'b1);
	endtask

	task automatic check_idle(input int bits);
		for (int i = 0; i < bits * CPB; i++)
		begin
			@(negedge clk);
			compare_line("tx_o idle", tx_o, 1'b1);
		end
	endtask

	// whole-run limit
	initial
	begin
		repeat (200000) @(posedge clk);
		stop_with_failure("simulation did not finish within the cycle limit");
	end

	initial
	begin
		resetn = 1'b0;
		rx_i = 1'b1;
		cycles_per_bit = `UART_CPB_W'(CPB);
		rnd_state = 32'd60;
		repeat (16) @(posedge clk);
		#1 resetn = 1'b1;

		check_idle(40);

		for (int i = 0; i < NV; i++)
		begin
			fork
				send_byte(VECS[i][15:8]);
				receive_byte(got_a);
			join
			compare_byte("tx data", got_a, VECS[i][7:0]);
		end

		// two commands back to back, both responses must arrive
		fork
			begin
				send_byte(8'h37);
				send_byte(8'hB0);
			end
			begin
				receive_byte(got_a);
				receive_byte(got_b);
			end
		join
		compare_byte("tx data first of pair", got_a, 8'hC7);
		compare_byte("tx data second of pair", got_b, 8'hC7);

		reg0_model = 8'h10;
		for (int i = 0; i < 20; i++)
		begin
			rnd_state = xorshift(rnd_state);
			cmd = {2'b11, rnd_state[5:0]};
			reg0_model = reg0_model + {2'b00, rnd_state[5:0]}; // mod 256
			fork
				send_byte(cmd);
				receive_byte(got_a);
			join
			compare_byte("tx data addi", got_a, reg0_model);
		end

		check_idle(20); // no extra frame after the last command
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/cmd_decode.sv ====
/*
	Turns one received byte into a command, one cycle after rx_valid_i.
	OP_ADDI always yields address 0.
*/
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module cmd_decode
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic [`UART_DATA_BITS-1:0] rx_byte_i,
	input wire logic rx_valid_i,
	output uart_pkg::cmd_t cmd_o
);

	uart_pkg::cmd_word_u word;
	uart_pkg::cmd_t cmd_d;
	uart_pkg::cmd_t cmd_q;
	logic valid_q;

	always_comb
	begin
		word = rx_byte_i;
		cmd_d.op = word.regs.op; // op sits in the same bits in both views
		cmd_d.valid = rx_valid_i;
		if (word.regs.op == uart_pkg::OP_ADDI)
		begin
			cmd_d.addr = '0;
			cmd_d.operand = `UART_DATA_BITS'(word.arith.imm);
		end
		else
		begin
			cmd_d.addr = word.regs.addr;
			cmd_d.operand = `UART_DATA_BITS'(word.regs.nib);
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			valid_q <= 1'b0;
		else
			valid_q <= rx_valid_i;
	end

	always_ff @(posedge clk)
	begin
		if (rx_valid_i)
			cmd_q <= cmd_d;
	end

	assign cmd_o = '{op: cmd_q.op, addr: cmd_q.addr, operand: cmd_q.operand, valid: valid_q};

endmodule

`default_nettype wire

// ==== verilog/reg_execute.sv ====
/*
	Four 8-bit registers driven by decoded commands.
	Register update and response come from the same edge.
	The response carries the register value after the update.
*/
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module reg_execute
(
	input wire logic clk,
	input wire logic resetn,
	input wire uart_pkg::cmd_t cmd_i,
	output uart_pkg::resp_t resp_o
);

	localparam int NW = uart_pkg::NIB_W;

	logic [`UART_NUM_REGS-1:0][`UART_DATA_BITS-1:0] regs_q;
	logic [uart_pkg::ADDR_W-1:0] target;
	logic [`UART_DATA_BITS-1:0] cur;
	logic [`UART_DATA_BITS-1:0] nxt;
	logic [`UART_DATA_BITS-1:0] data_q;
	logic valid_q;

	always_comb
	begin
		target = (cmd_i.op == uart_pkg::OP_ADDI) ? '0 : cmd_i.addr;
		cur = regs_q[target];
		case (cmd_i.op)
			uart_pkg::OP_WR_LO: nxt = {cur[`UART_DATA_BITS-1:NW], cmd_i.operand[NW-1:0]};
			uart_pkg::OP_WR_HI: nxt = {cmd_i.operand[NW-1:0], cur[NW-1:0]};
			uart_pkg::OP_ADDI: nxt = cur + cmd_i.operand; // wraps mod 256
			default: nxt = cur; // read
		endcase
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			regs_q <= '0;
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= cmd_i.valid;
			if (cmd_i.valid)
				regs_q[target] <= nxt;
		end
	end

	always_ff @(posedge clk)
	begin
		if (cmd_i.valid)
			data_q <= nxt;
	end

	assign resp_o = '{data: data_q, valid: valid_q};

endmodule

`default_nettype wire

// ==== verilog/resp_result.sv ====
/*
	Single holding slot between execute and the transmitter.
	Host and responder share one baud rate, so one slot never overflows.
*/
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module resp_result
(
	input wire logic clk,
	input wire logic resetn,
	input wire uart_pkg::resp_t resp_i,
	input wire logic tx_busy_i,
	output logic [`UART_DATA_BITS-1:0] tx_data_o,
	output logic tx_start_o
);

	logic pending_q;
	logic [`UART_DATA_BITS-1:0] data_q;

	// launch as soon as the transmitter is free
	assign tx_start_o = pending_q & ~tx_busy_i;
	assign tx_data_o = data_q;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			pending_q <= 1'b0;
		else if (resp_i.valid)
			pending_q <= 1'b1; // a new arrival wins over a launch
		else if (tx_start_o)
			pending_q <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (resp_i.valid)
			data_q <= resp_i.data;
	end

endmodule

`default_nettype wire

// ==== verilog/uart_cmd_top.sv ====
/*
	Register command responder reached over a UART line.
	One response frame is sent per accepted command byte.
*/
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_cmd_top
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic rx_i,
	input wire logic [`UART_CPB_W-1:0] cycles_per_bit_i,
	output logic tx_o
);

	logic [`UART_DATA_BITS-1:0] rx_byte;
	logic rx_valid;
	uart_pkg::cmd_t cmd;
	uart_pkg::resp_t resp;
	logic [`UART_DATA_BITS-1:0] tx_data;
	logic tx_start;
	logic tx_busy;

	uart_rx i_rx
	(
		.clk(clk),
		.resetn(resetn),
		.rx_i(rx_i),
		.cycles_per_bit_i(cycles_per_bit_i),
		.rx_byte_o(rx_byte),
		.rx_valid_o(rx_valid)
	);

	cmd_decode i_decode
	(
		.clk(clk),
		.resetn(resetn),
		.rx_byte_i(rx_byte),
		.rx_valid_i(rx_valid),
		.cmd_o(cmd)
	);

	reg_execute i_execute
	(
		.clk(clk),
		.resetn(resetn),
		.cmd_i(cmd),
		.resp_o(resp)
	);

	resp_result i_result
	(
		.clk(clk),
		.resetn(resetn),
		.resp_i(resp),
		.tx_busy_i(tx_busy),
		.tx_data_o(tx_data),
		.tx_start_o(tx_start)
	);

	uart_tx i_tx
	(
		.clk(clk),
		.resetn(resetn),
		.tx_start_i(tx_start),
		.cycles_per_bit_i(cycles_per_bit_i),
		.tx_data_i(tx_data),
		.tx_o(tx_o),
		.tx_busy_o(tx_busy)
	);

endmodule

`default_nettype wire

// ==== verilog/uart_pkg.sv ====
/*
	Types passed between the responder stages.
	A command byte is op[7:6] followed by either addr/nibble or a 6-bit immediate.
*/
`default_nettype none

`include "uart_params.svh"

package uart_pkg;

	localparam int ADDR_W = $clog2(`UART_NUM_REGS);
	localparam int NIB_W = `UART_DATA_BITS / 2;
	localparam int IMM_W = `UART_DATA_BITS - 2;

	typedef enum logic [1:0]
	{
		OP_WR_LO = 2'd0, // low nibble write
		OP_WR_HI = 2'd1,
		OP_READ = 2'd2,
		OP_ADDI = 2'd3 // always targets reg 0
	} opcode_e;

	// register opcodes
	typedef struct packed
	{
		opcode_e op;
		logic [ADDR_W-1:0] addr;
		logic [NIB_W-1:0] nib;
	} cmd_reg_t;

	typedef struct packed
	{
		opcode_e op;
		logic [IMM_W-1:0] imm; // unsigned
	} cmd_arith_t;

	// same received byte, two decodings
	typedef union packed
	{
		cmd_reg_t regs;
		cmd_arith_t arith;
	} cmd_word_u;

	typedef struct packed
	{
		opcode_e op;
		logic [ADDR_W-1:0] addr;
		logic [`UART_DATA_BITS-1:0] operand; // nibble or zero-extended imm
		logic valid;
	} cmd_t;

	typedef struct packed
	{
		logic [`UART_DATA_BITS-1:0] data;
		logic valid;
	} resp_t;

endpackage

`default_nettype wire

// ==== verilog/uart_rx.sv ====
/*
	8N1 receiver. rx_i is asynchronous and passes a two-flop synchronizer.
	Start bits shorter than half a bit are rejected; a low stop bit drops the byte.
	rx_byte_o is only meaningful while rx_valid_o is high.
*/
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_rx
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic rx_i,
	input wire logic [`UART_CPB_W-1:0] cycles_per_bit_i,
	output logic [`UART_DATA_BITS-1:0] rx_byte_o,
	output logic rx_valid_o
);

	localparam int IDX_W = $clog2(`UART_DATA_BITS);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	rx_state_e state_q;
	logic [1:0] sync_q;
	logic rx_s;
	logic [`UART_CPB_W-1:0] cnt_q;
	logic [`UART_CPB_W-1:0] half_m1;
	logic [`UART_CPB_W-1:0] full_m1;
	logic [IDX_W-1:0] idx_q;
	logic [`UART_DATA_BITS-1:0] shift_q;

	assign rx_s = sync_q[1];
	assign half_m1 = (cycles_per_bit_i >> 1) - `UART_CPB_W'(1);
	assign full_m1 = cycles_per_bit_i - `UART_CPB_W'(1);

	// line idles high, so sync flops reset to 1
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			sync_q <= 2'b11;
		else
			sync_q <= {sync_q[0], rx_i};
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			state_q <= RX_IDLE;
			cnt_q <= '0;
			idx_q <= '0;
			rx_valid_o <= 1'b0;
		end
		else
		begin
			rx_valid_o <= 1'b0;
			case (state_q)
				RX_IDLE:
				begin
					cnt_q <= '0;
					if (!rx_s)
						state_q <= RX_START;
				end
				RX_START:
				begin
					if (cnt_q == half_m1)
					begin
						cnt_q <= '0;
						idx_q <= '0;
						state_q <= rx_s ? RX_IDLE : RX_DATA; // glitch, back to idle
					end
					else
						cnt_q <= cnt_q + 1'b1;
				end
				RX_DATA:
				begin
					if (cnt_q == full_m1)
					begin
						cnt_q <= '0;
						idx_q <= idx_q + 1'b1;
						if (idx_q == IDX_W'(`UART_DATA_BITS - 1))
							state_q <= RX_STOP;
					end
					else
						cnt_q <= cnt_q + 1'b1;
				end
				RX_STOP:
				begin
					if (cnt_q == full_m1)
					begin
						rx_valid_o <= rx_s; // framing error drops the byte
						state_q <= RX_IDLE;
					end
					else
						cnt_q <= cnt_q + 1'b1;
				end
				default: state_q <= RX_IDLE;
			endcase
		end
	end

	// lsb first, shift in from the top
	always_ff @(posedge clk)
	begin
		if (state_q == RX_DATA && cnt_q == full_m1)
			shift_q <= {rx_s, shift_q[`UART_DATA_BITS-1:1]};
	end

	assign rx_byte_o = shift_q;

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
/*
	8N1 transmitter, start is a one-cycle strobe ignored while busy.
	Frame lasts 10 * cycles_per_bit_i cycles; cycles_per_bit_i must be >= 2.
	Data is captured on the start edge.
*/
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_tx
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic tx_start_i,
	input wire logic [`UART_CPB_W-1:0] cycles_per_bit_i,
	input wire logic [`UART_DATA_BITS-1:0] tx_data_i,
	output logic tx_o,
	output logic tx_busy_o
);

	localparam int IDX_W = $clog2(`UART_FRAME_BITS);

	typedef enum logic [1:0] {TX_IDLE, TX_PREP, TX_SEND, TX_ADV} tx_state_e;

	tx_state_e state_q;
	logic [`UART_CPB_W-1:0] cnt_q;
	logic [`UART_CPB_W-1:0] cnt_end;
	logic [IDX_W-1:0] idx_q;
	logic [`UART_FRAME_BITS-1:0] frame_q;

	// SEND covers cpb-1 cycles, ADV the last cycle of the bit
	assign cnt_end = cycles_per_bit_i - `UART_CPB_W'(2);

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			state_q <= TX_IDLE;
			cnt_q <= '0;
			idx_q <= '0;
		end
		else
		begin
			case (state_q)
				TX_IDLE:
					if (tx_start_i)
						state_q <= TX_PREP;
				TX_PREP:
				begin
					cnt_q <= '0;
					idx_q <= '0;
					state_q <= TX_SEND;
				end
				TX_SEND:
				begin
					if (cnt_q == cnt_end)
						state_q <= TX_ADV;
					else
						cnt_q <= cnt_q + 1'b1;
				end
				TX_ADV:
				begin
					cnt_q <= '0;
					idx_q <= idx_q + 1'b1;
					if (idx_q == IDX_W'(`UART_FRAME_BITS - 1))
						state_q <= TX_IDLE; // stop bit done
					else
						state_q <= TX_SEND;
				end
				default: state_q <= TX_IDLE;
			endcase
		end
	end

	// stop, data, start from msb down
	always_ff @(posedge clk)
	begin
		if (state_q == TX_IDLE && tx_start_i)
			frame_q <= {1'b1, tx_data_i, 1'b0};
	end

	assign tx_busy_o = (state_q != TX_IDLE);
	assign tx_o = (state_q == TX_SEND || state_q == TX_ADV) ? frame_q[idx_q] : 1'b1;

endmodule

`default_nettype wire
